//--- rv_fetch_pkg.sv
package rv_fetch_pkg;

    localparam int IADDR_BITS       = 16;
    localparam logic [IADDR_BITS-1:0] RESET_ADDR = 16'h0000;
    localparam int IMEM_WORDS_BITS  = 10;  // 1K words of instruction RAM
    localparam int QUEUE_DEPTH_BITS = 2;   // Four queue entries

    // Defined illegal compressed instruction
    localparam logic [15:0] OPC_ILLEGAL = 16'h0000;

    // Compressed quadrants, bits [1:0] of a halfword
    localparam logic [1:0] RVC_Q0 = 2'b00;
    localparam logic [1:0] RVC_Q1 = 2'b01;
    localparam logic [1:0] RVC_Q2 = 2'b10;

    // RV32I major opcodes produced by the expander
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_OP     = 7'b0110011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    typedef struct packed {
        logic [15:0] hi;
        logic [15:0] lo;
    } fetch_halves_t;

    // A memory word seen as one instruction or as two halfwords
    typedef union packed {
        logic [31:0]   word;
        fetch_halves_t half;
    } fetch_word_t;

endpackage

//--- rv_decode_comp.sv
module rv_decode_comp
(
    input  rv_fetch_pkg::fetch_word_t i_instr,
    output logic [31:0]               o_instr,
    output logic                      o_illegal
);

    logic [15:0] c;
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [4:0]  rs1p;        // Compressed register fields map to x8..x15
    logic [4:0]  rs2p;
    logic [11:0] imm6;
    logic [9:0]  imm_4spn;
    logic [11:0] imm_16sp;
    logic [11:0] off_lw;
    logic [11:0] off_lwsp;
    logic [11:0] off_swsp;
    logic [20:0] off_j;
    logic [12:0] off_b;
    logic [31:0] exp;
    logic        bad;

    assign c    = i_instr.half.lo;
    assign rd   = c[11:7];
    assign rs2  = c[6:2];
    assign rs1p = {2'b01, c[9:7]};
    assign rs2p = {2'b01, c[4:2]};

    // Immediates, scrambled per the RVC formats
    assign imm6     = {{6{c[12]}}, c[12], c[6:2]};
    assign imm_4spn = {c[10:7], c[12:11], c[5], c[6], 2'b00};
    assign imm_16sp = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0000};
    assign off_lw   = {5'b00000, c[5], c[12:10], c[6], 2'b00};
    assign off_lwsp = {4'b0000, c[3:2], c[12], c[6:4], 2'b00};
    assign off_swsp = {4'b0000, c[8:7], c[12:9], 2'b00};
    assign off_j    = {{10{c[12]}}, c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
    assign off_b    = {{5{c[12]}}, c[6:5], c[2], c[11:10], c[4:3], 1'b0};

    always_comb
    begin
        exp = '0;
        bad = 1'b0;
        case (c[1:0])
            rv_fetch_pkg::RVC_Q0:
            begin
                case (c[15:13])
                    3'b000:   // c.addi4spn
                    begin
                        bad = (c == rv_fetch_pkg::OPC_ILLEGAL) || (imm_4spn == '0);
                        exp = {2'b00, imm_4spn, 5'd2, 3'b000, rs2p, rv_fetch_pkg::OP_IMM};
                    end
                    3'b010:   // c.lw
                        exp = {off_lw, rs1p, 3'b010, rs2p, rv_fetch_pkg::OP_LOAD};
                    3'b110:   // c.sw
                        exp = {off_lw[11:5], rs2p, rs1p, 3'b010, off_lw[4:0],
                               rv_fetch_pkg::OP_STORE};
                    default:
                        bad = 1'b1;   // FP loads/stores and reserved
                endcase
            end
            rv_fetch_pkg::RVC_Q1:
            begin
                case (c[15:13])
                    3'b000:   // c.addi, c.nop
                        exp = {imm6, rd, 3'b000, rd, rv_fetch_pkg::OP_IMM};
                    3'b001:   // c.jal
                        exp = {off_j[20], off_j[10:1], off_j[11], off_j[19:12], 5'd1,
                               rv_fetch_pkg::OP_JAL};
                    3'b010:   // c.li
                        exp = {imm6, 5'd0, 3'b000, rd, rv_fetch_pkg::OP_IMM};
                    3'b011:
                    begin
                        if (rd == 5'd2)
                        begin
                            bad = (imm_16sp == '0);
                            exp = {imm_16sp, 5'd2, 3'b000, 5'd2, rv_fetch_pkg::OP_IMM};
                        end
                        else
                        begin
                            bad = !c[12] && (c[6:2] == '0);  // nzimm must be nonzero
                            exp = {{15{c[12]}}, c[6:2], rd, rv_fetch_pkg::OP_LUI};
                        end
                    end
                    3'b100:   // ALU group on x8..x15
                    begin
                        case (c[11:10])
                            2'b00:
                            begin
                                bad = c[12];  // shamt[5] reserved on RV32
                                exp = {7'b0000000, rs2, rs1p, 3'b101, rs1p,
                                       rv_fetch_pkg::OP_IMM};
                            end
                            2'b01:
                            begin
                                bad = c[12];
                                exp = {7'b0100000, rs2, rs1p, 3'b101, rs1p,
                                       rv_fetch_pkg::OP_IMM};
                            end
                            2'b10:
                                exp = {imm6, rs1p, 3'b111, rs1p, rv_fetch_pkg::OP_IMM};
                            default:
                            begin
                                bad = c[12];  // RV64 subw/addw
                                case (c[6:5])
                                    2'b00:
                                        exp = {7'b0100000, rs2p, rs1p, 3'b000, rs1p,
                                               rv_fetch_pkg::OP_OP};
                                    2'b01:
                                        exp = {7'b0000000, rs2p, rs1p, 3'b100, rs1p,
                                               rv_fetch_pkg::OP_OP};
                                    2'b10:
                                        exp = {7'b0000000, rs2p, rs1p, 3'b110, rs1p,
                                               rv_fetch_pkg::OP_OP};
                                    default:
                                        exp = {7'b0000000, rs2p, rs1p, 3'b111, rs1p,
                                               rv_fetch_pkg::OP_OP};
                                endcase
                            end
                        endcase
                    end
                    3'b101:   // c.j
                        exp = {off_j[20], off_j[10:1], off_j[11], off_j[19:12], 5'd0,
                               rv_fetch_pkg::OP_JAL};
                    default:  // c.beqz / c.bnez
                        exp = {off_b[12], off_b[10:5], 5'd0, rs1p, 2'b00, c[13],
                               off_b[4:1], off_b[11], rv_fetch_pkg::OP_BRANCH};
                endcase
            end
            rv_fetch_pkg::RVC_Q2:
            begin
                case (c[15:13])
                    3'b000:   // c.slli
                    begin
                        bad = c[12];
                        exp = {7'b0000000, rs2, rd, 3'b001, rd, rv_fetch_pkg::OP_IMM};
                    end
                    3'b010:   // c.lwsp
                    begin
                        bad = (rd == 5'd0);
                        exp = {off_lwsp, 5'd2, 3'b010, rd, rv_fetch_pkg::OP_LOAD};
                    end
                    3'b100:
                    begin
                        if (!c[12] && rs2 == 5'd0)          // c.jr
                        begin
                            bad = (rd == 5'd0);
                            exp = {12'd0, rd, 3'b000, 5'd0, rv_fetch_pkg::OP_JALR};
                        end
                        else if (!c[12])                    // c.mv
                            exp = {7'b0000000, rs2, 5'd0, 3'b000, rd, rv_fetch_pkg::OP_OP};
                        else if (rs2 == 5'd0 && rd == 5'd0) // c.ebreak
                            exp = {12'd1, 5'd0, 3'b000, 5'd0, rv_fetch_pkg::OP_SYSTEM};
                        else if (rs2 == 5'd0)               // c.jalr
                            exp = {12'd0, rd, 3'b000, 5'd1, rv_fetch_pkg::OP_JALR};
                        else                                // c.add
                            exp = {7'b0000000, rs2, rd, 3'b000, rd, rv_fetch_pkg::OP_OP};
                    end
                    3'b110:   // c.swsp
                        exp = {off_swsp[11:5], rs2, 5'd2, 3'b010, off_swsp[4:0],
                               rv_fetch_pkg::OP_STORE};
                    default:
                        bad = 1'b1;
                endcase
            end
            default:
                exp = '0;   // Full-size word, passed through below
        endcase
    end

    assign o_illegal = (c[1:0] != 2'b11) && bad;
    assign o_instr   = (c[1:0] == 2'b11) ? i_instr.word : (bad ? 32'd0 : exp);

endmodule

//--- rv_fetch_queue.sv
module rv_fetch_queue
(
    input  logic                                  i_clk,
    input  logic                                  i_reset,
    input  logic                                  i_flush,
    input  logic                                  i_push,
    input  logic [rv_fetch_pkg::IADDR_BITS+32:0]  i_data,
    input  logic                                  i_pop,
    output logic [rv_fetch_pkg::IADDR_BITS+32:0]  o_data,
    output logic                                  o_empty,
    output logic [rv_fetch_pkg::QUEUE_DEPTH_BITS:0] o_count
);

    logic [rv_fetch_pkg::IADDR_BITS+32:0]  mem [0:2**rv_fetch_pkg::QUEUE_DEPTH_BITS-1];
    logic [rv_fetch_pkg::QUEUE_DEPTH_BITS-1:0] wr_ptr;
    logic [rv_fetch_pkg::QUEUE_DEPTH_BITS-1:0] rd_ptr;
    logic                                      do_pop;

    assign o_empty = (o_count == '0);
    assign do_pop  = i_pop && !o_empty;   // Pop on empty is ignored
    assign o_data  = mem[rd_ptr];

    always_ff @(posedge i_clk)
    begin
        if (i_reset || i_flush)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            o_count <= '0;
        end
        else
        begin
            if (i_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (i_push && !do_pop)
                o_count <= o_count + 1'b1;
            else if (do_pop && !i_push)
                o_count <= o_count - 1'b1;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_push)
            mem[wr_ptr] <= i_data;
    end

endmodule

//--- rv_fetch.sv
module rv_fetch
(
    input  logic                                i_clk,
    input  logic                                i_reset,
    input  logic                                i_stall,
    input  logic                                i_flush,
    input  logic                                i_pc_select,
    input  logic [rv_fetch_pkg::IADDR_BITS-1:0] i_pc_target,
    input  logic                                i_ebreak,
    input  logic [rv_fetch_pkg::IADDR_BITS-1:0] i_pc_trap,
    input  logic                                i_ack,
    input  rv_fetch_pkg::fetch_word_t           i_rdata,
    output logic                                o_cyc,
    output logic [rv_fetch_pkg::IADDR_BITS-1:0] o_addr,
    output logic [31:0]                         o_instr,
    output logic [rv_fetch_pkg::IADDR_BITS-1:0] o_pc,
    output logic                                o_illegal,
    output logic                                o_ready
);

    logic [rv_fetch_pkg::IADDR_BITS-1:0]    pc;
    logic [rv_fetch_pkg::IADDR_BITS-1:0]    fetch_pc;
    logic [2:0]                             pc_incr;
    logic                                   run;
    logic                                   pending;
    logic                                   discard;
    logic [15:0]                            buf_hi;
    logic                                   buf_valid;
    logic                                   redirect;
    logic                                   resp_valid;
    logic                                   is_comp;
    logic                                   hold_half;
    logic                                   push;
    rv_fetch_pkg::fetch_word_t              exp_in;
    logic [31:0]                            exp_instr;
    logic                                   exp_illegal;
    logic [rv_fetch_pkg::IADDR_BITS+32:0]   queue_out;
    logic                                   queue_empty;
    logic [rv_fetch_pkg::QUEUE_DEPTH_BITS:0] queue_count;

    assign redirect   = i_ebreak || i_pc_select;
    assign resp_valid = i_ack && pending && !discard && !redirect;

    // Pick the halfword that starts at pc, or finish a split instruction
    always_comb
    begin
        if (buf_valid)
        begin
            exp_in.half.lo = buf_hi;
            exp_in.half.hi = i_rdata.half.lo;
        end
        else if (pc[1])
        begin
            exp_in.half.lo = i_rdata.half.hi;
            exp_in.half.hi = 16'h0000;
        end
        else
            exp_in.word = i_rdata.word;
    end

    assign is_comp   = (exp_in.half.lo[1:0] != 2'b11);
    assign hold_half = resp_valid && !buf_valid && pc[1] && !is_comp;  // Needs next word
    assign push      = resp_valid && !hold_half;
    assign pc_incr   = is_comp ? 3'd2 : 3'd4;

    // A split instruction fetches the word after the buffered half
    assign fetch_pc = buf_valid ? pc + 2'd2 : pc;
    assign o_addr   = {fetch_pc[rv_fetch_pkg::IADDR_BITS-1:2], 2'b00};

    // One request in flight, and only with room for its push
    assign o_cyc = run && !pending && !queue_count[rv_fetch_pkg::QUEUE_DEPTH_BITS];

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            pc        <= rv_fetch_pkg::RESET_ADDR;
            run       <= 1'b0;
            pending   <= 1'b0;
            discard   <= 1'b0;
            buf_valid <= 1'b0;
        end
        else
        begin
            run     <= 1'b1;
            pending <= o_cyc || (pending && !i_ack);
            if (redirect)
            begin
                pc        <= i_ebreak ? i_pc_trap : i_pc_target;  // Trap wins
                discard   <= o_cyc;    // Response to this cycle's request is stale
                buf_valid <= 1'b0;
            end
            else
            begin
                if (i_ack)
                    discard <= 1'b0;
                if (push)
                    pc <= pc + pc_incr;
                if (hold_half)
                    buf_valid <= 1'b1;
                else if (push)
                    buf_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (hold_half)
            buf_hi <= i_rdata.half.hi;
    end

    rv_decode_comp u_decode_comp
    (
        .i_instr        (exp_in),
        .o_instr        (exp_instr),
        .o_illegal      (exp_illegal)
    );

    rv_fetch_queue u_fetch_queue
    (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_flush        (i_flush || redirect),
        .i_push         (push),
        .i_data         ({pc, exp_instr, exp_illegal}),
        .i_pop          (!i_stall),
        .o_data         (queue_out),
        .o_empty        (queue_empty),
        .o_count        (queue_count)
    );

    assign {o_pc, o_instr, o_illegal} = queue_out;
    assign o_ready = !queue_empty;

endmodule

//--- rv_imem.sv
module rv_imem
(
    input  logic                                     i_clk,
    input  logic                                     i_cyc,
    input  logic [rv_fetch_pkg::IADDR_BITS-1:0]      i_addr,
    output logic                                     o_ack,
    output logic [31:0]                              o_rdata,
    input  logic                                     i_load_we,
    input  logic [rv_fetch_pkg::IMEM_WORDS_BITS-1:0] i_load_addr,
    input  logic [31:0]                              i_load_data
);

    logic [31:0]                              mem [0:2**rv_fetch_pkg::IMEM_WORDS_BITS-1];
    logic [rv_fetch_pkg::IMEM_WORDS_BITS-1:0] word_idx;

    // Byte address to word index
    assign word_idx = i_addr[rv_fetch_pkg::IMEM_WORDS_BITS+1:2];

    always_ff @(posedge i_clk)
    begin
        if (i_load_we)
            mem[i_load_addr] <= i_load_data;
        if (i_cyc)
            o_rdata <= mem[word_idx];
        o_ack <= i_cyc;   // Fixed one-cycle latency
    end

endmodule

//--- rv_fetch_top.sv
module rv_fetch_top
(
    input  logic                                     i_clk,
    input  logic                                     i_reset,
    input  logic                                     i_stall,
    input  logic                                     i_flush,
    input  logic                                     i_pc_select,
    input  logic [rv_fetch_pkg::IADDR_BITS-1:0]      i_pc_target,
    input  logic                                     i_ebreak,
    input  logic [rv_fetch_pkg::IADDR_BITS-1:0]      i_pc_trap,
    input  logic                                     i_load_we,
    input  logic [rv_fetch_pkg::IMEM_WORDS_BITS-1:0] i_load_addr,
    input  logic [31:0]                              i_load_data,
    output logic [31:0]                              o_instr,
    output logic [rv_fetch_pkg::IADDR_BITS-1:0]      o_pc,
    output logic                                     o_illegal,
    output logic                                     o_ready
);

    logic                                mem_cyc;
    logic [rv_fetch_pkg::IADDR_BITS-1:0] mem_addr;
    logic                                mem_ack;
    rv_fetch_pkg::fetch_word_t           mem_rdata;

    rv_fetch u_rv_fetch
    (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_stall        (i_stall),
        .i_flush        (i_flush),
        .i_pc_select    (i_pc_select),
        .i_pc_target    (i_pc_target),
        .i_ebreak       (i_ebreak),
        .i_pc_trap      (i_pc_trap),
        .i_ack          (mem_ack),
        .i_rdata        (mem_rdata),
        .o_cyc          (mem_cyc),
        .o_addr         (mem_addr),
        .o_instr        (o_instr),
        .o_pc           (o_pc),
        .o_illegal      (o_illegal),
        .o_ready        (o_ready)
    );

    rv_imem u_rv_imem
    (
        .i_clk          (i_clk),
        .i_cyc          (mem_cyc),
        .i_addr         (mem_addr),
        .o_ack          (mem_ack),
        .o_rdata        (mem_rdata),
        .i_load_we      (i_load_we),
        .i_load_addr    (i_load_addr),
        .i_load_data    (i_load_data)
    );

endmodule

//--- rv_fetch_assert.sv
module rv_fetch_assert
(
    input logic                                  i_clk,
    input logic                                  i_reset,
    input logic                                  i_cyc,
    input logic                                  i_ack,
    input logic                                  i_ready,
    input logic                                  i_push,
    input logic [rv_fetch_pkg::QUEUE_DEPTH_BITS:0] i_count
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;   // Failed assertions so far

    // One request in flight at most, its answer comes alone next cycle
    assert property (@(posedge i_clk) disable iff (i_reset) i_cyc |=> (i_ack && !i_cyc))
    else
    begin
        $error("o_cyc high while a response is pending");
        fail_count++;
    end

    assert property (@(posedge i_clk) disable iff (i_reset)
                     !(i_push && i_count[rv_fetch_pkg::QUEUE_DEPTH_BITS]))
    else
    begin
        $error("push into a full queue");
        fail_count++;
    end

    // Bus and decode side quiet once reset has been seen
    assert property (@(posedge i_clk) i_reset |=> (!i_cyc && !i_ready))
    else
    begin
        $error("o_cyc or o_ready active during reset");
        fail_count++;
    end

endmodule

bind rv_fetch rv_fetch_assert u_fetch_assert
(
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_cyc      (o_cyc),
    .i_ack      (i_ack),
    .i_ready    (o_ready),
    .i_push     (push),
    .i_count    (queue_count)
);

//--- tb_rv_fetch.sv
module tb_rv_fetch;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT = 200;  // Cycles per wait

    logic                                     i_clk;
    logic                                     i_reset;
    logic                                     i_stall;
    logic                                     i_flush;
    logic                                     i_pc_select;
    logic [rv_fetch_pkg::IADDR_BITS-1:0]      i_pc_target;
    logic                                     i_ebreak;
    logic [rv_fetch_pkg::IADDR_BITS-1:0]      i_pc_trap;
    logic                                     i_load_we;
    logic [rv_fetch_pkg::IMEM_WORDS_BITS-1:0] i_load_addr;
    logic [31:0]                              i_load_data;
    logic [31:0]                              o_instr;
    logic [rv_fetch_pkg::IADDR_BITS-1:0]      o_pc;
    logic                                     o_illegal;
    logic                                     o_ready;

    // Program image as halfwords, and the entries decode should see
    logic [15:0]                         halves [0:511];
    logic [rv_fetch_pkg::IADDR_BITS-1:0] exp_pc [0:255];
    logic [31:0]                         exp_instr [0:255];
    logic                                exp_ill [0:255];
    logic [15:0]                         comp_code [0:7];   // Hand-expanded RVC pairs
    logic [31:0]                         comp_exp [0:7];
    int                                  n_half;
    int                                  n_exp;
    int                                  mismatches;
    int                                  failures;
    logic [31:0]                         lfsr;
    logic                                random_stall;

    rv_fetch_top u_rv_fetch_top (.*);

    initial
    begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic check_instr(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp)
        begin
            $display("MISMATCH %s instr: expected %h, actual %h", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_pc(input string name, input logic [rv_fetch_pkg::IADDR_BITS-1:0] exp,
                            input logic [rv_fetch_pkg::IADDR_BITS-1:0] act);
        if (act !== exp)
        begin
            $display("MISMATCH %s pc: expected %h, actual %h", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_illegal(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("MISMATCH %s illegal: expected %b, actual %b", name, exp, act);
            mismatches++;
        end
    endtask

    // PC follows from the halfwords already placed, +2 or +4 per entry
    task automatic add_instr(input logic [31:0] code, input logic [31:0] exp, input logic ill);
        int byte_addr;
        byte_addr = 2 * n_half;
        exp_pc[n_exp]    = byte_addr[rv_fetch_pkg::IADDR_BITS-1:0];
        exp_instr[n_exp] = exp;
        exp_ill[n_exp]   = ill;
        n_exp++;
        halves[n_half] = code[15:0];
        n_half++;
        if (code[1:0] == 2'b11)
        begin
            halves[n_half] = code[31:16];
            n_half++;
        end
    endtask

    task automatic add_table(input logic [2:0] idx);
        add_instr({16'h0000, comp_code[idx]}, comp_exp[idx], 1'b0);
    endtask

    task automatic add_random_full();
        logic [31:0] w;
        take_bits(32, w);
        w[1:0] = 2'b11;
        add_instr(w, w, 1'b0);
    endtask

    // Loads the image plus a few fill words, then holds reset 10 more cycles
    task automatic reset_and_load();
        int n_words;
        if (n_half % 2 == 1)
            halves[n_half] = 16'h0001;   // c.nop pad
        n_words = (n_half + 1) / 2;
        @(posedge i_clk);
        #2;
        i_reset = 1'b1;
        i_stall = 1'b1;
        for (int i = 0; i < n_words + 8; i++)
        begin
            i_load_we   = 1'b1;
            i_load_addr = i[rv_fetch_pkg::IMEM_WORDS_BITS-1:0];
            if (i < n_words)
                i_load_data = {halves[2*i+1], halves[2*i]};
            else
                i_load_data = {6'd0, i_load_addr, 9'd0, 7'h13};
            @(posedge i_clk);
            #2;
        end
        i_load_we = 1'b0;
        repeat (10) @(posedge i_clk);
        #2;
        i_reset = 1'b0;
    endtask

    task automatic pulse_ctrl(input logic sel, input logic brk, input logic flush);
        i_pc_select = sel;
        i_ebreak    = brk;
        i_flush     = flush;
        @(posedge i_clk);
        #2;
        i_pc_select = 1'b0;
        i_ebreak    = 1'b0;
        i_flush     = 1'b0;
    endtask

    task automatic wait_ready(input string name);
        for (int t = 0; t < TIMEOUT && !o_ready; t++)
        begin
            @(posedge i_clk);
            #2;
        end
        if (!o_ready)
        begin
            $display("%s: o_ready never rose", name);
            failures++;
        end
    endtask

    // Decode model, pops one entry and compares it with entry idx
    task automatic pop_check(input string name, input int idx);
        logic [31:0] r;
        int          t;
        for (t = 0; t < TIMEOUT; t++)
        begin
            r = '0;
            if (random_stall)
                take_bits(1, r);
            i_stall = r[0];
            @(negedge i_clk);
            if (o_ready && !i_stall)
                break;
            @(posedge i_clk);
            #2;
        end
        if (t == TIMEOUT)
        begin
            $display("%s: entry %0d did not arrive within %0d cycles", name, idx, TIMEOUT);
            failures++;
        end
        else
        begin
            check_pc(name, exp_pc[idx], o_pc);
            check_instr(name, exp_instr[idx], o_instr);
            check_illegal(name, exp_ill[idx], o_illegal);
            @(posedge i_clk);
            #2;
        end
        i_stall = 1'b1;
    endtask

    task automatic check_stream(input string name, input int first, input int count);
        for (int i = 0; i < count; i++)
            pop_check(name, first + i);
    endtask

    task automatic test_aligned();
        n_half = 0;
        n_exp  = 0;
        for (int i = 0; i < 16; i++)
            add_random_full();
        reset_and_load();
        check_stream("aligned", 0, 16);
    endtask

    task automatic test_mixed();
        n_half = 0;
        n_exp  = 0;
        for (int i = 0; i < 8; i++)
        begin
            add_table(i[2:0]);
            if (i[0])
                add_table(3'd7 - i[2:0]);
            add_random_full();   // Split across words when pc[1] is set
        end
        reset_and_load();
        check_stream("mixed", 0, n_exp);
    endtask

    task automatic test_illegal();
        logic [15:0] bad [0:4];
        bad = '{16'h0000, 16'h0004, 16'h2000, 16'h8002, 16'h4002};
        n_half = 0;
        n_exp  = 0;
        for (int i = 0; i < 5; i++)
        begin
            add_instr({16'h0000, bad[i]}, 32'd0, 1'b1);
            add_table(i[2:0]);
        end
        reset_and_load();
        check_stream("illegal", 0, n_exp);
    endtask

    task automatic test_redirect();
        n_half = 0;
        n_exp  = 0;
        for (int i = 0; i < 12; i++)
        begin
            if (i % 3 == 2)
                add_random_full();
            else
                add_table(i[2:0]);
        end
        reset_and_load();
        wait_ready("redirect");
        i_pc_target = exp_pc[8];
        pulse_ctrl(1'b1, 1'b0, 1'b0);
        check_stream("redirect", 8, 4);
        i_pc_target = exp_pc[10];
        i_pc_trap   = exp_pc[3];   // Trap beats the redirect
        pulse_ctrl(1'b1, 1'b1, 1'b0);
        check_stream("trap", 3, 6);
    endtask

    task automatic test_random_stall();
        logic [31:0] r;
        n_half = 0;
        n_exp  = 0;
        for (int i = 0; i < 48; i++)
        begin
            take_bits(1, r);
            if (r[0])
                add_random_full();
            else
            begin
                take_bits(3, r);
                add_table(r[2:0]);
            end
        end
        reset_and_load();
        random_stall = 1'b1;
        check_stream("random_stall", 0, n_exp);
        random_stall = 1'b0;
    endtask

    task automatic test_flush();
        n_half = 0;
        n_exp  = 0;
        for (int i = 0; i < 10; i++)
        begin
            if (i[0])
                add_random_full();
            else
                add_table(i[2:0]);
        end
        reset_and_load();
        repeat (30) @(posedge i_clk);   // Fills the four entries at one per two cycles
        #2;
        if (!o_ready)
        begin
            $display("flush: queue empty before the flush");
            failures++;
        end
        pulse_ctrl(1'b0, 1'b0, 1'b1);
        if (o_ready)
        begin
            $display("flush: entries left in the queue after the flush");
            failures++;
        end
        check_stream("flush", 4, 6);   // Restart after the last flushed entry
    endtask

    initial
    begin
        i_reset      = 1'b1;
        i_stall      = 1'b1;
        i_flush      = 1'b0;
        i_pc_select  = 1'b0;
        i_pc_target  = '0;
        i_ebreak     = 1'b0;
        i_pc_trap    = '0;
        i_load_we    = 1'b0;
        i_load_addr  = '0;
        i_load_data  = '0;
        lfsr         = 32'h6960_326d;
        random_stall = 1'b0;
        mismatches   = 0;
        failures     = 0;
        // addi, li, mv, add, lw, j, ebreak, slli
        comp_code = '{16'h0085, 16'h557D, 16'h829A, 16'h929A,
                      16'h40C0, 16'hA021, 16'h9002, 16'h008E};
        comp_exp  = '{32'h0010_8093, 32'hFFF0_0513, 32'h0060_02B3, 32'h0062_82B3,
                      32'h0044_A403, 32'h0080_006F, 32'h0010_0073, 32'h0030_9093};
        test_aligned();
        test_mixed();
        test_illegal();
        test_redirect();
        test_random_stall();
        test_flush();
        failures += u_rv_fetch_top.u_rv_fetch.u_fetch_assert.fail_count;
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches + failures == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

//--- flist.f
rv_fetch_pkg.sv
rv_decode_comp.sv
rv_fetch_queue.sv
rv_fetch.sv
rv_imem.sv
rv_fetch_top.sv
rv_fetch_assert.sv
tb_rv_fetch.sv
